// File: source/uart_frame_pkg.sv
// shared definitions for the framed string transceiver
// framing byte, buffer map, buffer request struct and FSM encodings

package uart_frame_pkg;

	// framing byte, ascii '&'
	localparam logic [7:0] frame_char = 8'h26;

	// buffer map: 0..127 tx payload, 128..255 rx payload
	localparam int buf_addr_w = 8;
	localparam logic [buf_addr_w-1:0] rx_base = 8'd128;
	localparam logic [6:0] max_payload = 7'd127;

	typedef enum logic {
		buf_read  = 1'b0,
		buf_write = 1'b1
	} buf_op_e;

	// one buffer access, 17 bits
	typedef struct packed {
		buf_op_e               op;
		logic [buf_addr_w-1:0] addr;
		logic [7:0]            wdata;
	} buf_req_t;

	typedef enum logic [2:0] {
		ftx_idle,
		ftx_open1,
		ftx_open2,
		ftx_fetch,
		ftx_send_payload,
		ftx_close1,
		ftx_close2,
		ftx_done
	} ftx_state_e;

	typedef enum logic [2:0] {
		frx_hunt,
		frx_open2,
		frx_payload,
		frx_close2,
		frx_store_len
	} frx_state_e;

	// bit phases of the uart byte engines
	typedef enum logic [1:0] {
		ubit_idle,
		ubit_start,
		ubit_data,
		ubit_stop
	} ubit_state_e;

endpackage

// File: source/uart_tx.sv
// uart byte transmitter, 8N1
// start bit, 8 data bits lsb first, one stop bit
// done pulses once at the end of the stop bit

`timescale 1ns/1ps

module uart_tx
	import uart_frame_pkg::*;
#(
	parameter int clks_per_bit = 16
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       req,
	input  logic [7:0] data,
	output logic       tx,
	output logic       done
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

	ubit_state_e      state;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= ubit_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ubit_idle: begin
					tx <= 1'b1;
					// requests while busy are not seen here
					if (req) begin
						shreg   <= data;
						clk_cnt <= '0;
						tx      <= 1'b0;
						state   <= ubit_start;
					end
				end
				ubit_start: begin
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						tx      <= shreg[0];
						shreg   <= {1'b0, shreg[7:1]};
						state   <= ubit_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				ubit_data: begin
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7) begin
							tx    <= 1'b1;
							state <= ubit_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx      <= shreg[0];
							shreg   <= {1'b0, shreg[7:1]};
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				ubit_stop: begin
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						done    <= 1'b1;
						state   <= ubit_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= ubit_idle;
			endcase
		end
	end

endmodule

// File: source/uart_rx.sv
// uart byte receiver, 8N1
// two-flop synchronizer, start bit confirmed at half a bit,
// then every bit sampled in its middle; valid only on a good stop bit

`timescale 1ns/1ps

module uart_rx
	import uart_frame_pkg::*;
#(
	parameter int clks_per_bit = 16
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] data,
	output logic       valid
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

	ubit_state_e      state;
	logic             rx_meta;
	logic             rx_sync;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= ubit_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid   <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				ubit_idle: begin
					if (!rx_sync) begin
						clk_cnt <= '0;
						state   <= ubit_start;
					end
				end
				ubit_start: begin
					if (clk_cnt == half_last) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// glitch shorter than half a bit goes back to idle
						state   <= rx_sync ? ubit_idle : ubit_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				ubit_data: begin
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						shreg   <= {rx_sync, shreg[7:1]};
						if (bit_idx == 3'd7)
							state <= ubit_stop;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				ubit_stop: begin
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						valid   <= rx_sync;
						state   <= ubit_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= ubit_idle;
			endcase
		end
	end

	// shift register is stable until the next start bit
	assign data = shreg;

endmodule

// File: source/frame_tx.sv
// frame transmitter
// sends '&&', then length bytes read from buffer address 0 up, then '&&'
// one buffer fetch in flight at most, issued after the previous byte is out

`timescale 1ns/1ps

module frame_tx
	import uart_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       start_valid,
	input  logic [6:0] length,
	output logic       start_ready,
	output logic       done,
	output logic       buf_req_valid,
	output buf_req_t   buf_req,
	input  logic       buf_req_ready,
	input  logic [7:0] buf_rdata,
	input  logic       buf_rdata_valid,
	output logic       byte_req,
	output logic [7:0] byte_data,
	input  logic       byte_done
);

	ftx_state_e state;
	logic [6:0] len_q;
	logic [6:0] idx;
	logic       fetch_sent;

	assign start_ready = (state == ftx_idle);
	assign done        = (state == ftx_done);

	// read request for the next payload byte
	assign buf_req_valid = (state == ftx_fetch) && !fetch_sent;
	assign buf_req.op    = buf_read;
	assign buf_req.addr  = {1'b0, idx};
	assign buf_req.wdata = 8'h00;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= ftx_idle;
			len_q      <= '0;
			idx        <= '0;
			fetch_sent <= 1'b0;
			byte_req   <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				ftx_idle: begin
					if (start_valid) begin
						len_q     <= length;
						idx       <= '0;
						byte_req  <= 1'b1;
						byte_data <= frame_char;
						state     <= ftx_open1;
					end
				end
				ftx_open1: begin
					if (byte_done) begin
						byte_req  <= 1'b1;
						byte_data <= frame_char;
						state     <= ftx_open2;
					end
				end
				ftx_open2: begin
					if (byte_done) begin
						if (len_q == 7'd0) begin
							// empty payload, straight to the closing pair
							byte_req  <= 1'b1;
							byte_data <= frame_char;
							state     <= ftx_close1;
						end else begin
							state <= ftx_fetch;
						end
					end
				end
				ftx_fetch: begin
					if (buf_req_valid && buf_req_ready)
						fetch_sent <= 1'b1;
					if (buf_rdata_valid) begin
						fetch_sent <= 1'b0;
						idx        <= idx + 1'b1;
						byte_req   <= 1'b1;
						byte_data  <= buf_rdata;
						state      <= ftx_send_payload;
					end
				end
				ftx_send_payload: begin
					if (byte_done) begin
						if (idx == len_q) begin
							byte_req  <= 1'b1;
							byte_data <= frame_char;
							state     <= ftx_close1;
						end else begin
							state <= ftx_fetch;
						end
					end
				end
				ftx_close1: begin
					if (byte_done) begin
						byte_req  <= 1'b1;
						byte_data <= frame_char;
						state     <= ftx_close2;
					end
				end
				ftx_close2: begin
					if (byte_done)
						state <= ftx_done;
				end
				ftx_done: state <= ftx_idle;
				default:  state <= ftx_idle;
			endcase
		end
	end

endmodule

// File: source/frame_rx.sv
// frame receiver
// hunts for '&&', writes payload bytes from rx_base upward,
// checks the closing '&&' and reports the payload length

`timescale 1ns/1ps

module frame_rx
	import uart_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       byte_valid,
	input  logic [7:0] byte_data,
	output logic       buf_req_valid,
	output buf_req_t   buf_req,
	input  logic       buf_req_ready,
	output logic       done,
	output logic [6:0] length
);

	frx_state_e            state;
	logic [6:0]            cnt;
	logic                  pend;
	logic [buf_addr_w-1:0] pend_addr;
	logic [7:0]            pend_data;
	logic                  is_frame_char;

	assign is_frame_char = (byte_data == frame_char);

	// one pending write at most, top priority drains it next cycle
	assign buf_req_valid = pend;
	assign buf_req.op    = buf_write;
	assign buf_req.addr  = pend_addr;
	assign buf_req.wdata = pend_data;

	assign done = (state == frx_store_len);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state  <= frx_hunt;
			cnt    <= '0;
			pend   <= 1'b0;
			length <= '0;
		end else begin
			if (pend && buf_req_ready)
				pend <= 1'b0;
			case (state)
				frx_hunt: begin
					if (byte_valid && is_frame_char)
						state <= frx_open2;
				end
				frx_open2: begin
					if (byte_valid) begin
						cnt   <= '0;
						state <= is_frame_char ? frx_payload : frx_hunt;
					end
				end
				frx_payload: begin
					if (byte_valid) begin
						if (is_frame_char) begin
							state <= frx_close2;
						end else if (cnt != max_payload) begin
							pend      <= 1'b1;
							pend_addr <= rx_base + {1'b0, cnt};
							pend_data <= byte_data;
							cnt       <= cnt + 1'b1;
						end
						// beyond max_payload the byte is dropped
					end
				end
				frx_close2: begin
					if (byte_valid) begin
						if (is_frame_char) begin
							length <= cnt;
							state  <= frx_store_len;
						end else begin
							// broken close, no report
							state <= frx_hunt;
						end
					end
				end
				frx_store_len: state <= frx_hunt;
				default:       state <= frx_hunt;
			endcase
		end
	end

endmodule

// File: source/string_buf.sv
// shared 256 x 8 string buffer
// three request ports in fixed priority: frame_rx, frame_tx, host
// one access per cycle, read data returns one cycle after the grant

`timescale 1ns/1ps

module string_buf
	import uart_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx_req_valid,
	input  buf_req_t   rx_req,
	output logic       rx_req_ready,
	input  logic       tx_req_valid,
	input  buf_req_t   tx_req,
	output logic       tx_req_ready,
	input  logic       host_req_valid,
	input  buf_req_t   host_req,
	output logic       host_req_ready,
	output logic [7:0] rdata,
	output logic       tx_rdata_valid,
	output logic       host_rdata_valid
);

	logic [7:0] mem [0:(1 << buf_addr_w) - 1];
	logic       arb_en;
	logic       rx_fire;
	logic       tx_fire;
	logic       host_fire;
	logic       any_fire;
	buf_req_t   sel_req;

	// ports stay closed for the first cycle out of reset
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			arb_en <= 1'b0;
		else
			arb_en <= 1'b1;
	end

	assign rx_req_ready   = arb_en;
	assign tx_req_ready   = arb_en && !rx_req_valid;
	assign host_req_ready = arb_en && !rx_req_valid && !tx_req_valid;

	assign rx_fire   = rx_req_valid && rx_req_ready;
	assign tx_fire   = tx_req_valid && tx_req_ready;
	assign host_fire = host_req_valid && host_req_ready;
	assign any_fire  = rx_fire || tx_fire || host_fire;

	always_comb begin
		if (rx_fire)
			sel_req = rx_req;
		else if (tx_fire)
			sel_req = tx_req;
		else
			sel_req = host_req;
	end

	always_ff @(posedge sys_clk) begin
		if (any_fire) begin
			if (sel_req.op == buf_write)
				mem[sel_req.addr] <= sel_req.wdata;
			else
				rdata <= mem[sel_req.addr];
		end
	end

	// read return goes back to whichever port won
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_rdata_valid   <= 1'b0;
			host_rdata_valid <= 1'b0;
		end else begin
			tx_rdata_valid   <= tx_fire && (tx_req.op == buf_read);
			host_rdata_valid <= host_fire && (host_req.op == buf_read);
		end
	end

endmodule

// File: source/uart_frame_top.sv
// framed string transceiver top level
// host buffer port, frame transmitter and receiver, uart byte engines

`timescale 1ns/1ps

module uart_frame_top
	import uart_frame_pkg::*;
#(
	parameter int clks_per_bit = 16
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       host_req_valid,
	input  buf_req_t   host_req,
	output logic       host_req_ready,
	output logic [7:0] host_rdata,
	output logic       host_rdata_valid,
	input  logic       tx_start_valid,
	input  logic [6:0] tx_length,
	output logic       tx_start_ready,
	output logic       tx_done,
	output logic       rx_done,
	output logic [6:0] rx_length,
	input  logic       uart_rx_port,
	output logic       uart_tx_port
);

	// internal buffer ports
	logic     rx_req_valid;
	buf_req_t rx_req;
	logic     rx_req_ready;
	logic     tx_req_valid;
	buf_req_t tx_req;
	logic     tx_req_ready;
	logic     tx_rdata_valid;

	// byte strobes
	logic       byte_tx_req;
	logic [7:0] byte_tx_data;
	logic       byte_tx_done;
	logic       byte_rx_valid;
	logic [7:0] byte_rx_data;

	string_buf buf_i (
		.sys_clk          (sys_clk),
		.sys_rst_n        (sys_rst_n),
		.rx_req_valid     (rx_req_valid),
		.rx_req           (rx_req),
		.rx_req_ready     (rx_req_ready),
		.tx_req_valid     (tx_req_valid),
		.tx_req           (tx_req),
		.tx_req_ready     (tx_req_ready),
		.host_req_valid   (host_req_valid),
		.host_req         (host_req),
		.host_req_ready   (host_req_ready),
		.rdata            (host_rdata),
		.tx_rdata_valid   (tx_rdata_valid),
		.host_rdata_valid (host_rdata_valid)
	);

	frame_tx frame_tx_i (
		.sys_clk         (sys_clk),
		.sys_rst_n       (sys_rst_n),
		.start_valid     (tx_start_valid),
		.length          (tx_length),
		.start_ready     (tx_start_ready),
		.done            (tx_done),
		.buf_req_valid   (tx_req_valid),
		.buf_req         (tx_req),
		.buf_req_ready   (tx_req_ready),
		.buf_rdata       (host_rdata),
		.buf_rdata_valid (tx_rdata_valid),
		.byte_req        (byte_tx_req),
		.byte_data       (byte_tx_data),
		.byte_done       (byte_tx_done)
	);

	frame_rx frame_rx_i (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.byte_valid    (byte_rx_valid),
		.byte_data     (byte_rx_data),
		.buf_req_valid (rx_req_valid),
		.buf_req       (rx_req),
		.buf_req_ready (rx_req_ready),
		.done          (rx_done),
		.length        (rx_length)
	);

	uart_tx #(
		.clks_per_bit (clks_per_bit)
	) uart_tx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.req       (byte_tx_req),
		.data      (byte_tx_data),
		.tx        (uart_tx_port),
		.done      (byte_tx_done)
	);

	uart_rx #(
		.clks_per_bit (clks_per_bit)
	) uart_rx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.data      (byte_rx_data),
		.valid     (byte_rx_valid)
	);

endmodule

// File: dv/uart_frame_checker.sv
// checker for the framed string transceiver
// keeps a buffer model from host writes and the received serial line,
// decodes both serial pins and compares frames, read data and reports

`timescale 1ns/1ps

module uart_frame_checker
	import uart_frame_pkg::*;
#(
	parameter int clks_per_bit = 8,
	parameter int clk_ns       = 40
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       host_req_valid,
	input  buf_req_t   host_req,
	input  logic       host_req_ready,
	input  logic [7:0] host_rdata,
	input  logic       host_rdata_valid,
	input  logic       tx_start_valid,
	input  logic [6:0] tx_length,
	input  logic       tx_start_ready,
	input  logic       tx_done,
	input  logic       rx_done,
	input  logic [6:0] rx_length,
	input  logic       uart_tx_port,
	input  logic       uart_rx_port,
	input  logic       test_end,
	output int         err_cnt
);

	localparam int bit_ns = clks_per_bit * clk_ns;

	logic [7:0] model [256];
	logic [7:0] tx_expect [$];
	logic       tx_busy = 1'b0;
	logic       rx_pend = 1'b0;
	logic [6:0] rx_exp_len = '0;
	logic [6:0] rx_len_q = '0;
	logic       rd_pend = 1'b0;
	logic [7:0] rd_addr = '0;

	initial err_cnt = 0;

	task automatic flag_mismatch(input string what, input logic [7:0] got,
			input logic [7:0] want);
		$display("** Error at %0d ns: %s, got %02h, expected %02h", $time, what, got, want);
		err_cnt++;
	endtask

	task automatic flag_failure(input string what);
		$display("%s (at %0d ns)", what, $time);
		err_cnt++;
	endtask

	// one 8N1 byte off a pin sampled a quarter clock past mid-bit
	task automatic read_serial(input bit from_rx, output logic [7:0] b, output logic stop);
		if (from_rx)
			@(negedge uart_rx_port);
		else
			@(negedge uart_tx_port);
		#(bit_ns + bit_ns / 2 + clk_ns / 4);
		for (int i = 0; i < 8; i++) begin
			b[i] = from_rx ? uart_rx_port : uart_tx_port;
			#(bit_ns);
		end
		stop = from_rx ? uart_rx_port : uart_tx_port;
	endtask

	// transmitted bytes against the frame expected at start
	initial begin : tx_line
		logic [7:0] b;
		logic [7:0] want;
		logic       stop;
		forever begin
			read_serial(1'b0, b, stop);
			if (!stop)
				flag_failure("stop bit low on uart_tx_port");
			if (tx_expect.size() == 0) begin
				flag_failure("byte on uart_tx_port outside a started frame");
			end else begin
				want = tx_expect.pop_front();
				if (b !== want)
					flag_mismatch("uart_tx_port byte", b, want);
			end
		end
	end

	// framing rules applied to whatever reaches uart_rx_port
	initial begin : rx_line
		logic [7:0] b;
		logic       stop;
		int         st;
		int         cnt;
		st  = 0;
		cnt = 0;
		forever begin
			read_serial(1'b1, b, stop);
			if (!stop)
				flag_failure("stop bit low on uart_rx_port");
			case (st)
				0: begin
					if (b == frame_char)
						st = 1;
				end
				1: begin
					st  = (b == frame_char) ? 2 : 0;
					cnt = 0;
				end
				2: begin
					if (b == frame_char) begin
						st = 3;
					end else if (cnt < max_payload) begin
						model[rx_base + cnt] = b;
						cnt++;
					end
				end
				default: begin
					// only a second '&' closes the frame
					if (b == frame_char) begin
						rx_exp_len = 7'(cnt);
						rx_pend    = 1'b1;
					end
					st = 0;
				end
			endcase
		end
	end

	always @(posedge sys_clk) begin
		if (sys_rst_n) begin
			// read data due exactly one cycle after the handshake
			if (rd_pend && !host_rdata_valid)
				flag_failure("host_rdata_valid missing one cycle after a read handshake");
			else if (rd_pend && host_rdata !== model[rd_addr])
				flag_mismatch("host_rdata", host_rdata, model[rd_addr]);
			else if (!rd_pend && host_rdata_valid)
				flag_failure("host_rdata_valid without a read handshake");
			rd_pend = host_req_valid && host_req_ready && (host_req.op == buf_read);
			rd_addr = host_req.addr;
			if (host_req_valid && host_req_ready && (host_req.op == buf_write))
				model[host_req.addr] = host_req.wdata;

			// frame_tx takes a start only while no frame is in flight
			if (tx_start_ready !== !tx_busy)
				flag_failure("tx_start_ready does not follow the idle state of frame_tx");
			if (tx_start_valid && tx_start_ready) begin
				tx_expect = {frame_char, frame_char};
				for (int i = 0; i < tx_length; i++)
					tx_expect.push_back(model[i]);
				tx_expect.push_back(frame_char);
				tx_expect.push_back(frame_char);
				tx_busy = 1'b1;
			end
			if (tx_done) begin
				if (!tx_busy)
					flag_failure("tx_done without a started frame");
				else if (tx_expect.size() != 0)
					flag_failure("tx_done before the whole frame was on uart_tx_port");
				tx_busy = 1'b0;
			end

			if (rx_done) begin
				if (!rx_pend)
					flag_failure("rx_done without a well-formed frame on uart_rx_port");
				else if (rx_length !== rx_exp_len)
					flag_mismatch("rx_length", {1'b0, rx_length}, {1'b0, rx_exp_len});
				rx_pend = 1'b0;
			end else if (rx_length !== rx_len_q) begin
				flag_mismatch("rx_length moved without rx_done", {1'b0, rx_length},
					{1'b0, rx_len_q});
			end
			rx_len_q = rx_length;

			if (test_end) begin
				if (rx_pend)
					flag_failure("rx_done never came for a well-formed frame");
				if (tx_busy)
					flag_failure("tx_done never came for a started frame");
			end
		end
	end

endmodule

// File: dv/uart_frame_tb.sv
// testbench for the framed string transceiver
// table-driven host, start and serial stimulus with a loopback mux

`timescale 1ns/1ps

module uart_frame_tb
	import uart_frame_pkg::*;
();

	localparam int clks_per_bit = 8;
	localparam int clk_ns       = 40;
	localparam int n_rows       = 6;

	localparam logic [1:0] mode_rw   = 2'd0;
	localparam logic [1:0] mode_loop = 2'd1;
	localparam logic [1:0] mode_bad  = 2'd2;
	localparam logic [1:0] mode_load = 2'd3;

	typedef struct packed {
		logic [1:0] mode;
		logic [6:0] len;
	} test_row_t;

	logic       sys_clk = 1'b0;
	logic       sys_rst_n;
	logic       host_req_valid;
	buf_req_t   host_req;
	logic       host_req_ready;
	logic [7:0] host_rdata;
	logic       host_rdata_valid;
	logic       tx_start_valid;
	logic [6:0] tx_length;
	logic       tx_start_ready;
	logic       tx_done;
	logic       rx_done;
	logic [6:0] rx_length;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic       direct_mode;
	logic       drv_line;
	logic       test_end;
	int         err_cnt;
	int         tx_seen = 0;
	int         rx_seen = 0;
	int         rx_filled = 0;
	integer     seed = 28924;
	test_row_t  rows [n_rows];
	logic [7:0] payload [n_rows][128];

	always #(clk_ns / 2) sys_clk = ~sys_clk;

	// loopback unless the direct driver owns the line
	assign uart_rx_port = direct_mode ? drv_line : uart_tx_port;

	always @(posedge sys_clk) begin
		if (tx_done)
			tx_seen <= tx_seen + 1;
		if (rx_done)
			rx_seen <= rx_seen + 1;
	end

	uart_frame_top #(
		.clks_per_bit (clks_per_bit)
	) dut_i (
		.sys_clk          (sys_clk),
		.sys_rst_n        (sys_rst_n),
		.host_req_valid   (host_req_valid),
		.host_req         (host_req),
		.host_req_ready   (host_req_ready),
		.host_rdata       (host_rdata),
		.host_rdata_valid (host_rdata_valid),
		.tx_start_valid   (tx_start_valid),
		.tx_length        (tx_length),
		.tx_start_ready   (tx_start_ready),
		.tx_done          (tx_done),
		.rx_done          (rx_done),
		.rx_length        (rx_length),
		.uart_rx_port     (uart_rx_port),
		.uart_tx_port     (uart_tx_port)
	);

	uart_frame_checker #(
		.clks_per_bit (clks_per_bit),
		.clk_ns       (clk_ns)
	) check_i (.*);

	// one host transfer entered 1 ns after a rising edge
	task automatic host_access(input buf_op_e req_op, input logic [7:0] req_addr,
			input logic [7:0] req_wdata);
		logic granted;
		host_req_valid = 1'b1;
		host_req       = '{op: req_op, addr: req_addr, wdata: req_wdata};
		granted        = 1'b0;
		while (!granted) begin
			@(negedge sys_clk);
			granted = host_req_ready;
			@(posedge sys_clk);
			#1;
		end
		host_req_valid = 1'b0;
	endtask

	task automatic start_frame(input logic [6:0] len);
		logic granted;
		tx_start_valid = 1'b1;
		tx_length      = len;
		granted        = 1'b0;
		while (!granted) begin
			@(negedge sys_clk);
			granted = tx_start_ready;
			@(posedge sys_clk);
			#1;
		end
		tx_start_valid = 1'b0;
	endtask

	task automatic drive_serial(input logic [7:0] b);
		logic [9:0] frame_bits;
		frame_bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			drv_line = frame_bits[i];
			repeat (clks_per_bit) @(posedge sys_clk);
			#1;
		end
	endtask

	task automatic wait_frames(input int tx_target, input int rx_target);
		wait (tx_seen >= tx_target && rx_seen >= rx_target);
		@(posedge sys_clk);
		#1;
	endtask

	task automatic load_payload(input int r);
		for (int i = 0; i < rows[r].len; i++)
			host_access(buf_write, 8'(i), payload[r][i]);
	endtask

	task automatic read_back(input logic [7:0] base, input int n);
		for (int i = 0; i < n; i++)
			host_access(buf_read, base + 8'(i), 8'h00);
	endtask

	// reads every rx address filled so far to catch stray writes too
	task automatic read_rx_region(input int n);
		if (n > rx_filled)
			rx_filled = n;
		read_back(rx_base, rx_filled);
	endtask

	initial begin : main
		logic [7:0] ch;
		int         tx_t;
		int         rx_t;
		int         err_before;
		int         addr;
		sys_rst_n      = 1'b0;
		host_req_valid = 1'b0;
		host_req       = '0;
		tx_start_valid = 1'b0;
		tx_length      = '0;
		direct_mode    = 1'b0;
		drv_line       = 1'b1;
		test_end       = 1'b0;

		rows[0] = '{mode_rw, 7'd16};
		rows[1] = '{mode_loop, 7'd12};
		rows[2] = '{mode_loop, 7'd0};
		rows[3] = '{mode_bad, 7'd6};
		rows[4] = '{mode_load, 7'd20};
		rows[5] = '{mode_loop, 7'd127};
		// printable payload with '&' swapped for '*'
		for (int r = 0; r < n_rows; r++) begin
			for (int i = 0; i < 128; i++) begin
				ch = 8'h21 + 8'($unsigned($random(seed)) % 94);
				payload[r][i] = (ch == frame_char) ? 8'h2a : ch;
			end
		end

		repeat (5) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		@(posedge sys_clk);
		#1;

		for (int r = 0; r < n_rows; r++) begin
			err_before = err_cnt;
			tx_t = tx_seen + 1;
			rx_t = rx_seen + 1;
			case (rows[r].mode)
				mode_rw: begin
					load_payload(r);
					read_back(8'h00, rows[r].len);
				end
				mode_loop: begin
					load_payload(r);
					start_frame(rows[r].len);
					wait_frames(tx_t, rx_t);
					read_rx_region(rows[r].len);
				end
				mode_load: begin
					load_payload(r);
					start_frame(rows[r].len);
					addr = 64;
					// host traffic in the upper tx region while the frame runs
					while (tx_seen < tx_t) begin
						host_access(buf_write, 8'(addr), payload[r][addr]);
						host_access(buf_read, 8'(addr), 8'h00);
						addr = (addr == 127) ? 64 : addr + 1;
					end
					wait_frames(tx_t, rx_t);
					read_rx_region(rows[r].len);
				end
				default: begin
					direct_mode = 1'b1;
					// lone opening '&'
					drive_serial(frame_char);
					drive_serial(payload[r][0]);
					// broken close
					drive_serial(frame_char);
					drive_serial(frame_char);
					for (int i = 0; i < rows[r].len; i++)
						drive_serial(payload[r][i]);
					drive_serial(frame_char);
					drive_serial(8'h78);
					// good frame with other bytes
					drive_serial(frame_char);
					drive_serial(frame_char);
					for (int i = 0; i < rows[r].len; i++)
						drive_serial(payload[r][64 + i]);
					drive_serial(frame_char);
					drive_serial(frame_char);
					wait_frames(tx_seen, rx_t);
					direct_mode = 1'b0;
					read_rx_region(rows[r].len);
				end
			endcase
			test_end = 1'b1;
			@(posedge sys_clk);
			#1;
			test_end = 1'b0;
			repeat (2) @(posedge sys_clk);
			#1;
			$display("test %0d: mode %0d, length %0d, %0s", r, rows[r].mode, rows[r].len,
				(err_cnt == err_before) ? "passed" : "failed");
		end

		repeat (4) @(posedge sys_clk);
		$display("%0d tests run, %0d errors", n_rows, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// time limit from the frame lengths in the table
	initial begin : watchdog
		longint limit_ns;
		@(posedge sys_rst_n);
		limit_ns = 0;
		for (int r = 0; r < n_rows; r++)
			limit_ns += longint'(rows[r].len + 6) * 10 * clks_per_bit * clk_ns;
		limit_ns *= 2;
		#(limit_ns);
		$display("watchdog expired after %0d ns, the DUT stopped responding", limit_ns);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: uart_frame.f
source/uart_frame_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/frame_tx.sv
source/frame_rx.sv
source/string_buf.sv
source/uart_frame_top.sv
dv/uart_frame_checker.sv
dv/uart_frame_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the transceiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module uart_frame_tb \
	-f uart_frame.f -o uart_frame_sim

./obj_dir/uart_frame_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
	exit 0
else
	exit 1
fi
